// File: src/hps_bus_pkg.sv
// host bus package: word, count and keyboard types plus the user-io command codes

package hps_bus_pkg;

	//////////////////////////////////////////////////////////////////////
	// bus and register types
	//////////////////////////////////////////////////////////////////////

	// one word on the host bus
	typedef logic [15:0] bus_word_t;

	// byte address into the configuration string port
	typedef logic [9:0] cfg_addr_t;

	// keyboard scan byte as sent by the host
	typedef logic [7:0] ps2_byte_t;

	// up to 32 buttons per joystick
	typedef logic [31:0] joystick_t;

	// core status word, written in four 16-bit quarters
	typedef logic [63:0] status_t;

	// key event: [7:0] code, [8] extended, [9] pressed, [10] toggles per event
	typedef logic [10:0] ps2_key_t;

	//////////////////////////////////////////////////////////////////////
	// user-io command codes
	//////////////////////////////////////////////////////////////////////

	localparam bus_word_t cmd_cfg        = 16'h0001;
	localparam bus_word_t cmd_joy0       = 16'h0002;
	localparam bus_word_t cmd_joy1       = 16'h0003;
	localparam bus_word_t cmd_kbd        = 16'h0005;
	localparam bus_word_t cmd_conf_str   = 16'h0014;
	localparam bus_word_t cmd_status     = 16'h001e;
	localparam bus_word_t cmd_status_set = 16'h0029;

	// leads the status-set reply, the request counter follows it
	localparam logic [3:0] status_set_tag = 4'ha;

endpackage

// File: src/fio_pkg.sv
// file channel package: download command codes and ioctl address, index and extension types

package fio_pkg;

	// byte address of the download target
	typedef logic [26:0] ioctl_addr_t;

	// menu index the file was picked from
	typedef logic [15:0] ioctl_index_t;

	// file extension, first word in the high half
	typedef logic [31:0] file_ext_t;

	//////////////////////////////////////////////////////////////////////
	// file channel commands
	//////////////////////////////////////////////////////////////////////

	// start or stop, with an optional start address
	localparam logic [15:0] fio_file_tx     = 16'h0053;
	// one data byte per word
	localparam logic [15:0] fio_file_tx_dat = 16'h0054;
	localparam logic [15:0] fio_file_index  = 16'h0055;
	localparam logic [15:0] fio_file_info   = 16'h0056;

endpackage

// File: src/uio_cmd_decoder.sv
// user-io command decoder: configuration, joysticks, status, config string and key events
`timescale 1ns/1ns

module uio_cmd_decoder #(
	parameter int str_len = 16
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   io_strobe,
	input  logic                   io_enable,
	input  hps_bus_pkg::bus_word_t io_din,
	input  logic [7:0]             cfg_dout,
	input  hps_bus_pkg::status_t   status_in,
	input  logic                   status_set,
	output hps_bus_pkg::bus_word_t io_dout,
	output hps_bus_pkg::cfg_addr_t cfg_addr,
	output logic [1:0]             buttons,
	output logic                   forced_scandoubler,
	output hps_bus_pkg::joystick_t joystick_0,
	output hps_bus_pkg::joystick_t joystick_1,
	output hps_bus_pkg::status_t   status,
	output hps_bus_pkg::ps2_key_t  ps2_key,
	output hps_bus_pkg::ps2_byte_t kbd_byte,
	output logic                   kbd_we
);
	import hps_bus_pkg::*;

	// word counter wide enough for the string and the longest transfers
	localparam int cnt_w = $clog2((512 > str_len + 1) ? 512 : str_len + 1);

	typedef logic [cnt_w-1:0] byte_cnt_t;

	bus_word_t   cmd;
	byte_cnt_t   byte_cnt;
	bus_word_t   cfg;
	logic [1:0]  quarter;
	logic        quad_arg;

	// status-set request tracking
	logic        old_status_set;
	logic [3:0]  set_cnt;
	status_t     status_req;

	// keyboard history, newest byte in the low bits
	logic [31:0] kbd_raw;
	logic        kbd_skip;
	logic        pressed;
	logic        extended;
	logic [9:0]  key_bits;

	assign cfg_addr           = cfg_addr_t'(byte_cnt);
	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];

	// argument words 1 to 4 map onto the 16-bit quarters of a status word
	assign quarter  = 2'(byte_cnt - 1'b1);
	assign quad_arg = (byte_cnt < byte_cnt_t'(5));

	assign pressed  = (kbd_raw[15:8] != 8'hf0);
	// a release puts F0 between the E0 prefix and the code
	assign extended = pressed ? (kbd_raw[15:8] == 8'he0) : (kbd_raw[23:16] == 8'he0);

	always_comb begin
		key_bits = {pressed, extended, kbd_raw[7:0]};
		case (kbd_raw)
			// print screen press and release, pause press
			32'he012e07c: key_bits = 10'h37c;
			32'h7ce0f012: key_bits = 10'h17c;
			32'hf014f077: key_bits = 10'h377;
			default: ;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// status-set edge detection
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_status_set <= 1'b0;
			set_cnt        <= '0;
		end else begin
			old_status_set <= status_set;
			if (status_set && !old_status_set) begin
				set_cnt    <= set_cnt + 1'b1;
				status_req <= status_in;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// command and argument handling
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		kbd_we <= 1'b0;
		if (reset) begin
			cmd        <= '0;
			byte_cnt   <= '0;
			io_dout    <= '0;
			kbd_skip   <= 1'b0;
			cfg        <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
			ps2_key    <= '0;
		end else if (!io_enable) begin
			// transaction over, publish the key event once
			if (cmd == cmd_kbd && !kbd_skip) begin
				ps2_key <= {~ps2_key[10], key_bits};
			end
			cmd      <= '0;
			byte_cnt <= '0;
			io_dout  <= '0;
			kbd_skip <= 1'b0;
		end else if (io_strobe) begin
			io_dout <= '0;
			if (!(&byte_cnt)) begin
				byte_cnt <= byte_cnt + 1'b1;
			end

			if (byte_cnt == '0) begin
				cmd <= io_din;
				if (io_din == cmd_status_set) begin
					io_dout <= bus_word_t'({status_set_tag, set_cnt});
				end
				if (io_din == cmd_kbd) begin
					kbd_raw <= '0;
				end
			end else begin
				case (cmd)
					cmd_cfg: cfg <= io_din;

					cmd_joy0: begin
						if (byte_cnt == byte_cnt_t'(1)) begin
							joystick_0[15:0] <= io_din;
						end else if (byte_cnt == byte_cnt_t'(2)) begin
							joystick_0[31:16] <= io_din;
						end
					end

					cmd_joy1: begin
						if (byte_cnt == byte_cnt_t'(1)) begin
							joystick_1[15:0] <= io_din;
						end else if (byte_cnt == byte_cnt_t'(2)) begin
							joystick_1[31:16] <= io_din;
						end
					end

					cmd_kbd: begin
						// all ones in the high byte marks a skip
						if (&io_din[15:8]) begin
							kbd_skip <= 1'b1;
						end else if (!kbd_skip) begin
							kbd_raw  <= {kbd_raw[23:0], io_din[7:0]};
							kbd_byte <= io_din[7:0];
							kbd_we   <= 1'b1;
						end
					end

					// string byte comes back through the async port
					cmd_conf_str: begin
						if (byte_cnt <= byte_cnt_t'(str_len)) begin
							io_dout[7:0] <= cfg_dout;
						end
					end

					cmd_status: begin
						if (quad_arg) begin
							status[{quarter, 4'b0000} +: 16] <= io_din;
						end
					end

					cmd_status_set: begin
						if (quad_arg) begin
							io_dout <= status_req[{quarter, 4'b0000} +: 16];
						end
					end

					default: ;
				endcase
			end
		end
	end

endmodule

// File: src/file_downloader.sv
// file channel decoder: download strobes, running address, data, index and extension
`timescale 1ns/1ns

module file_downloader (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   io_strobe,
	input  logic                   fp_enable,
	input  hps_bus_pkg::bus_word_t io_din,
	output logic                   ioctl_download,
	output logic                   ioctl_wr,
	output fio_pkg::ioctl_addr_t   ioctl_addr,
	output logic [7:0]             ioctl_dout,
	output fio_pkg::ioctl_index_t  ioctl_index,
	output fio_pkg::file_ext_t     ioctl_file_ext
);
	import hps_bus_pkg::*;
	import fio_pkg::*;

	bus_word_t   cmd;
	logic        has_cmd;
	// argument number, stops at 3
	logic [1:0]  cnt;
	ioctl_addr_t addr;
	// one-stage delay in front of ioctl_wr
	logic        wr;

	always_ff @(posedge clk_sys) begin
		ioctl_wr <= wr;
		wr       <= 1'b0;
		if (reset) begin
			has_cmd        <= 1'b0;
			cnt            <= '0;
			ioctl_download <= 1'b0;
			ioctl_wr       <= 1'b0;
			wr             <= 1'b0;
		end else if (!fp_enable) begin
			has_cmd <= 1'b0;
		end else if (io_strobe) begin
			if (!has_cmd) begin
				cmd     <= io_din;
				has_cmd <= 1'b1;
				cnt     <= '0;
			end else begin
				if (cnt != 2'd3) begin
					cnt <= cnt + 1'b1;
				end
				case (cmd)
					fio_file_info: begin
						if (cnt == 2'd0) begin
							ioctl_file_ext[31:16] <= io_din;
						end else if (cnt == 2'd1) begin
							ioctl_file_ext[15:0] <= io_din;
						end
					end

					fio_file_index: ioctl_index <= io_din;

					fio_file_tx: begin
						case (cnt)
							2'd0: begin
								if (io_din[7:0] != 8'h00) begin
									addr           <= '0;
									ioctl_download <= 1'b1;
								end else begin
									if (ioctl_download) begin
										ioctl_addr <= addr;
									end
									ioctl_download <= 1'b0;
								end
							end
							// optional start address, low half first
							2'd1: begin
								ioctl_addr[15:0] <= io_din;
								addr[15:0]       <= io_din;
							end
							2'd2: begin
								ioctl_addr[26:16] <= io_din[10:0];
								addr[26:16]       <= io_din[10:0];
							end
							default: ;
						endcase
					end

					fio_file_tx_dat: begin
						if (ioctl_download) begin
							ioctl_addr <= addr;
							ioctl_dout <= io_din[7:0];
							wr         <= 1'b1;
							addr       <= addr + 1'b1;
						end
					end

					default: ;
				endcase
			end
		end
	end

endmodule

// File: src/ps2_keyboard_tx.sv
// PS/2 keyboard transmitter: clock divider, byte FIFO and device-to-host frame FSM
`timescale 1ns/1ns

module ps2_keyboard_tx #(
	parameter int ps2_div   = 2000,
	parameter int fifo_bits = 5
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  hps_bus_pkg::ps2_byte_t kbd_byte,
	input  logic                   kbd_we,
	output logic                   ps2_kbd_clk_out,
	output logic                   ps2_kbd_data_out
);
	import hps_bus_pkg::*;

	localparam int div_w = $clog2(ps2_div + 1);

	typedef enum logic [1:0] {
		st_idle,
		st_data,
		st_parity,
		st_stop
	} tx_state_t;

	logic [div_w-1:0]     div_cnt;
	logic                 clk_ps2;
	logic                 div_end;
	logic                 ps2_rise;
	logic                 ps2_fall;

	ps2_byte_t            fifo_mem [2**fifo_bits];
	logic [fifo_bits-1:0] wptr;
	logic [fifo_bits-1:0] rptr;
	logic                 fifo_empty;

	tx_state_t            state;
	ps2_byte_t            tx_byte;
	logic [2:0]           bit_cnt;
	logic                 parity;
	// idle edges left before a frame may start
	logic [1:0]           timeout;

	//////////////////////////////////////////////////////////////////////
	// ps/2 clock divider
	//////////////////////////////////////////////////////////////////////

	assign div_end  = (div_cnt == div_w'(ps2_div - 1));
	assign ps2_rise = div_end && !clk_ps2;
	assign ps2_fall = div_end && clk_ps2;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			div_cnt <= '0;
			clk_ps2 <= 1'b0;
		end else if (div_end) begin
			div_cnt <= '0;
			clk_ps2 <= ~clk_ps2;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// byte FIFO, overflow overwrites the oldest entries
	//////////////////////////////////////////////////////////////////////

	assign fifo_empty = (wptr == rptr);

	always_ff @(posedge clk_sys) begin
		if (kbd_we) begin
			fifo_mem[wptr] <= kbd_byte;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// frame FSM, data moves on the rising edge of the divided clock
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wptr             <= '0;
			rptr             <= '0;
			state            <= st_idle;
			bit_cnt          <= '0;
			timeout          <= 2'd3;
			ps2_kbd_clk_out  <= 1'b1;
			ps2_kbd_data_out <= 1'b1;
		end else begin
			if (kbd_we) begin
				wptr <= wptr + 1'b1;
			end

			if (ps2_rise) begin
				ps2_kbd_clk_out <= 1'b1;
				case (state)
					st_idle: begin
						if (!fifo_empty) begin
							timeout <= timeout - 1'b1;
							if (timeout == 2'd0) begin
								tx_byte          <= fifo_mem[rptr];
								rptr             <= rptr + 1'b1;
								parity           <= 1'b1;
								bit_cnt          <= '0;
								// start bit
								ps2_kbd_data_out <= 1'b0;
								state            <= st_data;
							end
						end
					end

					st_data: begin
						ps2_kbd_data_out <= tx_byte[0];
						tx_byte          <= {1'b0, tx_byte[7:1]};
						parity           <= parity ^ tx_byte[0];
						bit_cnt          <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7) begin
							state <= st_parity;
						end
					end

					// odd parity, bit_cnt has wrapped back to zero here
					st_parity: begin
						ps2_kbd_data_out <= parity;
						state            <= st_stop;
					end

					// drive the stop bit, then hold it for one more clock pulse
					st_stop: begin
						if (bit_cnt == 3'd0) begin
							ps2_kbd_data_out <= 1'b1;
							bit_cnt          <= 3'd1;
						end else begin
							state <= st_idle;
						end
					end

					default: state <= st_idle;
				endcase
			end

			// clock pulses low only while a frame is on the line
			if (ps2_fall) begin
				ps2_kbd_clk_out <= (state == st_idle);
			end
		end
	end

endmodule

// File: src/hps_io.sv
// host bus bridge top level: user-io decoder, file downloader and PS/2 keyboard
`timescale 1ns/1ns

module hps_io #(
	parameter int str_len   = 16,
	parameter int ps2_div   = 2000,
	parameter int fifo_bits = 5
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   io_strobe,
	input  logic                   io_enable,
	input  logic                   fp_enable,
	input  hps_bus_pkg::bus_word_t io_din,
	output hps_bus_pkg::bus_word_t io_dout,
	output hps_bus_pkg::cfg_addr_t cfg_addr,
	input  logic [7:0]             cfg_dout,
	output logic [1:0]             buttons,
	output logic                   forced_scandoubler,
	output hps_bus_pkg::joystick_t joystick_0,
	output hps_bus_pkg::joystick_t joystick_1,
	output hps_bus_pkg::status_t   status,
	input  hps_bus_pkg::status_t   status_in,
	input  logic                   status_set,
	output hps_bus_pkg::ps2_key_t  ps2_key,
	output logic                   ps2_kbd_clk_out,
	output logic                   ps2_kbd_data_out,
	output logic                   ioctl_download,
	output logic                   ioctl_wr,
	output fio_pkg::ioctl_addr_t   ioctl_addr,
	output logic [7:0]             ioctl_dout,
	output fio_pkg::ioctl_index_t  ioctl_index,
	output fio_pkg::file_ext_t     ioctl_file_ext
);
	import hps_bus_pkg::*;

	// keyboard bytes from the decoder to the PS/2 transmitter
	ps2_byte_t kbd_byte;
	logic      kbd_we;

	uio_cmd_decoder #(
		.str_len(str_len)
	) i_uio (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.io_strobe          (io_strobe),
		.io_enable          (io_enable),
		.io_din             (io_din),
		.cfg_dout           (cfg_dout),
		.status_in          (status_in),
		.status_set         (status_set),
		.io_dout            (io_dout),
		.cfg_addr           (cfg_addr),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.ps2_key            (ps2_key),
		.kbd_byte           (kbd_byte),
		.kbd_we             (kbd_we)
	);

	file_downloader i_fio (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.io_strobe      (io_strobe),
		.fp_enable      (fp_enable),
		.io_din         (io_din),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_index    (ioctl_index),
		.ioctl_file_ext (ioctl_file_ext)
	);

	ps2_keyboard_tx #(
		.ps2_div   (ps2_div),
		.fifo_bits (fifo_bits)
	) i_kbd (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.kbd_byte         (kbd_byte),
		.kbd_we           (kbd_we),
		.ps2_kbd_clk_out  (ps2_kbd_clk_out),
		.ps2_kbd_data_out (ps2_kbd_data_out)
	);

endmodule

// File: tests/hps_io_sva.sv
// bus and download timing assertions, bound to the bridge top level
`timescale 1ns/1ns

module hps_io_sva (
	input logic                   clk_sys,
	input logic                   reset,
	input logic                   io_enable,
	input hps_bus_pkg::bus_word_t io_dout,
	input logic                   ioctl_wr,
	input logic                   ioctl_download
);
	int fail_cnt = 0;

	// a write strobe only inside an active download
	a_wr_in_download: assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_wr |-> ioctl_download)
		else begin
			fail_cnt++;
			$error("ioctl_wr outside a download");
		end

	a_dout_cleared: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(io_enable) |=> (io_dout == '0))
		else begin
			fail_cnt++;
			$error("io_dout not cleared after io_enable fell");
		end

	a_wr_single: assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_wr |=> !ioctl_wr)
		else begin
			fail_cnt++;
			$error("ioctl_wr longer than one cycle");
		end

endmodule

bind hps_io hps_io_sva i_sva (.*);

// File: tests/hps_io_checker.sv
// response checker: bus replies, ioctl writes, output registers and PS/2 frames
`timescale 1ns/1ns

module hps_io_checker (
	input logic                   clk_sys,
	input logic                   reset,
	input logic                   io_enable,
	input logic                   io_strobe,
	input hps_bus_pkg::bus_word_t io_dout,
	input logic [1:0]             buttons,
	input logic                   forced_scandoubler,
	input hps_bus_pkg::joystick_t joystick_0,
	input hps_bus_pkg::joystick_t joystick_1,
	input hps_bus_pkg::status_t   status,
	input hps_bus_pkg::ps2_key_t  ps2_key,
	input logic                   ps2_kbd_clk_out,
	input logic                   ps2_kbd_data_out,
	input logic                   ioctl_download,
	input logic                   ioctl_wr,
	input fio_pkg::ioctl_addr_t   ioctl_addr,
	input logic [7:0]             ioctl_dout,
	input fio_pkg::ioctl_index_t  ioctl_index,
	input fio_pkg::file_ext_t     ioctl_file_ext
);
	import hps_bus_pkg::*;
	import fio_pkg::*;

	int value_errs = 0;
	int other_errs = 0;

	bus_word_t   reply_q [$];
	logic [34:0] write_q [$];
	ps2_byte_t   frame_q [$];

	logic        reply_due = 1'b0;
	logic        prev_ps2_clk = 1'b1;
	logic [10:0] frame;
	int          nbit = 0;

	task automatic expect_reply(input bus_word_t w);
		reply_q.push_back(w);
	endtask

	task automatic expect_write(input ioctl_addr_t a, input logic [7:0] d);
		write_q.push_back({a, d});
	endtask

	task automatic expect_frame(input ps2_byte_t b);
		frame_q.push_back(b);
	endtask

	function automatic int pending_frames();
		return frame_q.size();
	endfunction

	task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			value_errs++;
			$display("** Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic compare_outputs(input bus_word_t cfg, input joystick_t j0, input joystick_t j1,
			input status_t st, input ps2_key_t key, input logic dl, input ioctl_index_t idx,
			input file_ext_t ext);
		check("buttons", 64'(buttons), 64'(cfg[1:0]));
		check("forced_scandoubler", 64'(forced_scandoubler), 64'(cfg[4]));
		check("joystick_0", 64'(joystick_0), 64'(j0));
		check("joystick_1", 64'(joystick_1), 64'(j1));
		check("status", status, st);
		check("ps2_key", 64'(ps2_key), 64'(key));
		check("ioctl_download", 64'(ioctl_download), 64'(dl));
		check("ioctl_index", 64'(ioctl_index), 64'(idx));
		check("ioctl_file_ext", 64'(ioctl_file_ext), 64'(ext));
	endtask

	task automatic report_missing();
		if (frame_q.size() != 0) begin
			other_errs++;
			$display("%0d PS/2 frames were never sent", frame_q.size());
		end
		if (write_q.size() != 0) begin
			other_errs++;
			$display("%0d ioctl writes never happened", write_q.size());
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// per-cycle comparisons
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk_sys) begin
		if (reset) begin
			reply_due = 1'b0;
			nbit      = 0;
		end else begin
			// reply registered at the strobe edge, read one edge later
			if (reply_due) begin
				if (reply_q.size() == 0) begin
					other_errs++;
					$display("reply word seen with no expected value at %0t", $time);
				end else begin
					check("io_dout", 64'(io_dout), 64'(reply_q.pop_front()));
				end
			end
			reply_due = io_strobe && io_enable;

			if (ioctl_wr) begin
				if (write_q.size() == 0) begin
					other_errs++;
					$display("unexpected ioctl write at %0t", $time);
				end else begin
					check("ioctl write", 64'({ioctl_addr, ioctl_dout}), 64'(write_q.pop_front()));
				end
			end

			// receiver samples data on the falling PS/2 clock
			if (prev_ps2_clk && !ps2_kbd_clk_out) begin
				frame[nbit] = ps2_kbd_data_out;
				nbit++;
				if (nbit == 11) begin
					nbit = 0;
					check("ps2 start bit", 64'(frame[0]), 64'd0);
					check("ps2 stop bit", 64'(frame[10]), 64'd1);
					check("ps2 parity", 64'(^frame[9:1]), 64'd1);
					if (frame_q.size() == 0) begin
						other_errs++;
						$display("unexpected PS/2 frame at %0t", $time);
					end else begin
						check("ps2 byte", 64'(frame[8:1]), 64'(frame_q.pop_front()));
					end
				end
			end
		end
		prev_ps2_clk = ps2_kbd_clk_out;
	end

endmodule

// File: tests/tb_hps_io.sv
// bridge testbench: random bus transactions against a reference model
`timescale 1ns/1ns

module tb_hps_io;
	import hps_bus_pkg::*;
	import fio_pkg::*;

	localparam int str_len = 16;
	localparam int ps2_div = 4;
	localparam int n_kbd   = 24;
	// transactions of every phase, keyboard ones included
	localparam int n_trans = 8 + 16 + 12 + 2 + (n_kbd + 3) + 8;
	localparam int cycle_limit = n_trans * 40 + (n_kbd + 3) * 4 * 12 * 4 * ps2_div + 1000;

	logic clk_sys, reset, io_strobe, io_enable, fp_enable, status_set;
	bus_word_t io_din, io_dout;
	cfg_addr_t cfg_addr;
	logic [7:0] cfg_dout, ioctl_dout;
	logic [1:0] buttons;
	logic forced_scandoubler, ps2_kbd_clk_out, ps2_kbd_data_out, ioctl_download, ioctl_wr;
	joystick_t joystick_0, joystick_1;
	status_t status, status_in;
	ps2_key_t ps2_key;
	ioctl_addr_t ioctl_addr;
	ioctl_index_t ioctl_index;
	file_ext_t ioctl_file_ext;

	logic [31:0] lfsr = 32'hafd22c10;
	int cycles = 0;
	bus_word_t txw [0:31];
	int txn;

	// reference model state
	bus_word_t m_cfg = '0;
	joystick_t m_joy0 = '0;
	joystick_t m_joy1 = '0;
	status_t m_status = '0;
	status_t m_req = '0;
	ps2_key_t m_key = '0;
	logic [3:0] m_cnt = '0;
	logic m_dl = 1'b0;
	ioctl_addr_t m_addr = '0;
	ioctl_index_t m_index = 'x;
	file_ext_t m_ext = 'x;

	assign cfg_dout = cfg_addr[7:0] ^ 8'h5a;

	hps_io #(.str_len(str_len), .ps2_div(ps2_div), .fifo_bits(5)) i_dut (.*);

	hps_io_checker i_chk (.*);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// key event bits 9:0 from the raw byte history
	function automatic logic [9:0] key_model(input logic [31:0] raw);
		logic pr;
		logic ex;
		if (raw == 32'he012e07c) return 10'h37c;
		if (raw == 32'h7ce0f012) return 10'h17c;
		if (raw == 32'hf014f077) return 10'h377;
		pr = (raw[15:8] != 8'hf0);
		ex = pr ? (raw[15:8] == 8'he0) : (raw[23:16] == 8'he0);
		return {pr, ex, raw[7:0]};
	endfunction

	task automatic add_io(input bus_word_t w, input bus_word_t r);
		txw[txn] = w;
		txn++;
		i_chk.expect_reply(r);
	endtask

	task automatic add_fp(input bus_word_t w);
		txw[txn] = w;
		txn++;
	endtask

	task automatic run_xfer(input logic file_ch);
		@(posedge clk_sys);
		if (file_ch) fp_enable <= 1'b1;
		else io_enable <= 1'b1;
		for (int i = 0; i < txn; i++) begin
			repeat (1 + rand_bits(2)) @(posedge clk_sys);
			io_strobe <= 1'b1;
			io_din <= txw[i];
			@(posedge clk_sys);
			io_strobe <= 1'b0;
		end
		repeat (1 + rand_bits(2)) @(posedge clk_sys);
		io_enable <= 1'b0;
		fp_enable <= 1'b0;
		repeat (3) @(posedge clk_sys);
		i_chk.compare_outputs(m_cfg, m_joy0, m_joy1, m_status, m_key, m_dl, m_index, m_ext);
		txn = 0;
	endtask

	task automatic pulse_status_set();
		@(posedge clk_sys);
		status_in <= {rand_bits(32), rand_bits(32)};
		status_set <= 1'b1;
		@(posedge clk_sys);
		status_set <= 1'b0;
		m_req = status_in;
		m_cnt = m_cnt + 1'b1;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic kbd_xfer(input logic [31:0] bytes, input int n, input int skip_at);
		logic [31:0] raw;
		logic skip;
		ps2_byte_t b;
		raw = '0;
		skip = 1'b0;
		// keep the FIFO well below its depth
		while (i_chk.pending_frames() > 16) @(posedge clk_sys);
		add_io(cmd_kbd, '0);
		for (int i = 0; i < n; i++) begin
			b = bytes[8*(n-1-i) +: 8];
			if (i == skip_at) begin
				add_io({8'hff, b}, '0);
				skip = 1'b1;
			end else begin
				add_io({8'h00, b}, '0);
				if (!skip) begin
					raw = {raw[23:0], b};
					i_chk.expect_frame(b);
				end
			end
		end
		if (!skip) m_key = {~m_key[10], key_model(raw)};
		run_xfer(1'b0);
	endtask

	task automatic file_data(input int n);
		bus_word_t w;
		add_fp(fio_file_tx_dat);
		for (int i = 0; i < n; i++) begin
			w = rand_bits(16);
			add_fp(w);
			i_chk.expect_write(m_addr, w[7:0]);
			m_addr = m_addr + 1'b1;
		end
		run_xfer(1'b1);
	endtask

	task automatic file_session(input logic with_addr);
		bus_word_t lo;
		bus_word_t hi;
		lo = rand_bits(16);
		hi = rand_bits(16);
		add_fp(fio_file_tx);
		add_fp(16'h0001);
		m_addr = '0;
		if (with_addr) begin
			add_fp(lo);
			add_fp(hi);
			m_addr = {hi[10:0], lo};
		end
		m_dl = 1'b1;
		run_xfer(1'b1);
		file_data(1 + rand_bits(3));
		file_data(1 + rand_bits(3));
		add_fp(fio_file_tx);
		add_fp(16'h0000);
		m_dl = 1'b0;
		run_xfer(1'b1);
	endtask

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		reset = 1'b1;
		io_strobe = 1'b0;
		io_enable = 1'b0;
		fp_enable = 1'b0;
		io_din = '0;
		status_in = '0;
		status_set = 1'b0;
		txn = 0;
		repeat (5) @(posedge clk_sys);
		reset <= 1'b0;
		repeat (2) @(posedge clk_sys);

		for (int i = 0; i < 4; i++) begin
			m_index = rand_bits(16);
			add_fp(fio_file_index);
			add_fp(m_index);
			run_xfer(1'b1);
			m_ext = rand_bits(32);
			add_fp(fio_file_info);
			add_fp(m_ext[31:16]);
			add_fp(m_ext[15:0]);
			run_xfer(1'b1);
		end

		for (int i = 0; i < 16; i++) begin
			case (rand_bits(2))
				2'd1: begin
					m_joy0 = rand_bits(32);
					add_io(cmd_joy0, '0);
					add_io(m_joy0[15:0], '0);
					add_io(m_joy0[31:16], '0);
				end
				2'd2: begin
					m_joy1 = rand_bits(32);
					add_io(cmd_joy1, '0);
					add_io(m_joy1[15:0], '0);
					add_io(m_joy1[31:16], '0);
				end
				default: begin
					m_cfg = rand_bits(16);
					add_io(cmd_cfg, '0);
					add_io(m_cfg, '0);
				end
			endcase
			run_xfer(1'b0);
		end

		for (int i = 0; i < 6; i++) begin
			m_status = {rand_bits(32), rand_bits(32)};
			add_io(cmd_status, '0);
			for (int q = 0; q < 4; q++) add_io(m_status[16*q +: 16], '0);
			run_xfer(1'b0);
			repeat (1 + rand_bits(1)) pulse_status_set();
			add_io(cmd_status_set, {8'h00, status_set_tag, m_cnt});
			for (int q = 0; q < 4; q++) add_io(rand_bits(16), m_req[16*q +: 16]);
			run_xfer(1'b0);
		end

		for (int i = 0; i < 2; i++) begin
			add_io(cmd_conf_str, '0);
			for (int k = 1; k <= str_len + 1; k++) begin
				add_io(rand_bits(16), (k <= str_len) ? bus_word_t'(k ^ 8'h5a) : '0);
			end
			run_xfer(1'b0);
		end

		kbd_xfer(32'he012e07c, 4, 7);
		kbd_xfer(32'h7ce0f012, 4, 7);
		kbd_xfer(32'hf014f077, 4, 7);
		for (int i = 0; i < n_kbd; i++) begin
			kbd_xfer(rand_bits(32), 1 + rand_bits(2), (rand_bits(3) == 0) ? rand_bits(2) : 7);
		end

		file_session(1'b0);
		file_session(1'b1);

		for (int i = 0; i < 6000 && i_chk.pending_frames() != 0; i++) @(posedge clk_sys);
		i_chk.report_missing();
		repeat (4) @(posedge clk_sys);

		$display("errors: %0d value, %0d other, %0d assertion", i_chk.value_errs,
			i_chk.other_errs, i_dut.i_sva.fail_cnt);
		if (i_chk.value_errs + i_chk.other_errs + i_dut.i_sva.fail_cnt == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("run stopped after %0d cycles without finishing", cycle_limit);
			$display("Test failed");
			$finish;
		end
	end

endmodule

// File: hps_io.f
src/hps_bus_pkg.sv
src/fio_pkg.sv
src/uio_cmd_decoder.sv
src/file_downloader.sv
src/ps2_keyboard_tx.sv
src/hps_io.sv
tests/hps_io_sva.sv
tests/hps_io_checker.sv
tests/tb_hps_io.sv

// File: Bender.yml
package:
  name: hps_io

sources:
  - src/hps_bus_pkg.sv
  - src/fio_pkg.sv
  - src/uio_cmd_decoder.sv
  - src/file_downloader.sv
  - src/ps2_keyboard_tx.sv
  - src/hps_io.sv
  - target: test
    files:
      - tests/hps_io_sva.sv
      - tests/hps_io_checker.sv
      - tests/tb_hps_io.sv
